/* design/dcache_ifs.sv */
// Memory requester, fill and scan interfaces of the data cache.
`timescale 1ns/1ps
`default_nettype none

// Word-at-a-time memory bus. A word completes in the cycle mwait is low.
interface mem_req_if
    import dcache_pkg::*;
();
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
    word_t load;
    logic  mwait;

    modport requester (output ren, wen, addr, store, input load, mwait);
    modport server    (input ren, wen, addr, store, output load, mwait);
endinterface

interface fill_if
    import dcache_pkg::*;
();
    logic             fill_we;
    logic             fill_way;
    logic             fill_word;
    word_t            fill_data;
    logic [TAG_W-1:0] fill_tag;
    logic             mark_valid;
    logic             mark_dirty;
    logic             mark_clean;
    frame_t           victim_frame;
    logic             victim_way;

    modport driver (
        output fill_we, fill_way, fill_word, fill_data, fill_tag,
        output mark_valid, mark_dirty, mark_clean,
        input  victim_frame, victim_way
    );
    modport receiver (
        input  fill_we, fill_way, fill_word, fill_data, fill_tag,
        input  mark_valid, mark_dirty, mark_clean,
        output victim_frame, victim_way
    );
endinterface

interface scan_if
    import dcache_pkg::*;
();
    logic [IDX_W-1:0] scan_set;
    logic             scan_way;
    frame_t           scan_frame;
    logic             clear_dirty;

    modport driver   (output scan_set, scan_way, clear_dirty, input scan_frame);
    modport receiver (input scan_set, scan_way, clear_dirty, output scan_frame);
endinterface

`default_nettype wire

/* design/dcache_pkg.sv */
// Data cache geometry constants, address and frame types, engine state enums.
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;

    localparam int NUM_SETS = 8;
    localparam int NUM_WAYS = 2;
    localparam int IDX_W    = 3;
    localparam int TAG_W    = 26;

    // One slot per word: sets x ways x words.
    localparam int SLOT_W   = 5;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;
        logic [1:0]       bytoff;
    } dcache_addr_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
        word_t [1:0]      data;
    } frame_t;

    typedef enum logic [2:0] {
        MISS_IDLE,
        WB_WORD0,
        WB_WORD1,
        FILL_WORD0,
        FILL_WORD1
    } miss_state_t;

    typedef enum logic [1:0] {
        FLUSH_IDLE,
        FLUSH_SCAN,
        FLUSH_DONE
    } flush_state_t;

endpackage

`default_nettype wire

/* design/dcache_top.sv */
// Data cache top level with plain processor and memory ports.
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmemren,
    input  logic  dmemwen,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    input  logic  halt,
    output word_t dmemload,
    output logic  dhit,
    output logic  flushed,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_addr,
    output word_t mem_store,
    input  word_t mem_load,
    input  logic  mem_wait
);

    mem_req_if miss_mem  ();
    mem_req_if flush_mem ();
    mem_req_if bus_mem   ();
    fill_if    fill_bus  ();
    scan_if    scan_bus  ();

    logic miss;
    logic miss_busy;

    // The miss engine requests memory in every non-idle state.
    assign miss_busy = miss_mem.ren || miss_mem.wen;

    dcache_ways u_ways (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .miss      (miss),
        .fill      (fill_bus.receiver),
        .scan      (scan_bus.receiver)
    );

    miss_engine u_miss (
        .CLK      (CLK),
        .nRST     (nRST),
        .miss     (miss),
        .dmemwen  (dmemwen),
        .dmemaddr (dmemaddr),
        .fill     (fill_bus.driver),
        .mem      (miss_mem.requester)
    );

    flush_engine u_flush (
        .CLK     (CLK),
        .nRST    (nRST),
        .halt    (halt),
        .busy    (miss_busy),
        .flushed (flushed),
        .scan    (scan_bus.driver),
        .mem     (flush_mem.requester)
    );

    mem_arbiter u_arb (
        .CLK        (CLK),
        .nRST       (nRST),
        .miss_port  (miss_mem.server),
        .flush_port (flush_mem.server),
        .bus        (bus_mem.requester)
    );

    assign mem_ren       = bus_mem.ren;
    assign mem_wen       = bus_mem.wen;
    assign mem_addr      = bus_mem.addr;
    assign mem_store     = bus_mem.store;
    assign bus_mem.load  = mem_load;
    assign bus_mem.mwait = mem_wait;

endmodule

`default_nettype wire

/* design/dcache_ways.sv */
// Frame storage, LRU bits, tag compare and hit path of the data cache.
`timescale 1ns/1ps
`default_nettype none

module dcache_ways
    import dcache_pkg::*;
(
    input  logic   CLK,
    input  logic   nRST,
    input  logic   dmemren,
    input  logic   dmemwen,
    input  word_t  dmemaddr,
    input  word_t  dmemstore,
    output word_t  dmemload,
    output logic   dhit,
    output logic   miss,
    fill_if.receiver fill,
    scan_if.receiver scan
);

    frame_t [NUM_SETS-1:0][NUM_WAYS-1:0] frames;
    logic [NUM_SETS-1:0] lru;

    dcache_addr_t req;
    logic [NUM_WAYS-1:0] way_match;
    logic hit_way;
    logic active;

    assign req    = dcache_addr_t'(dmemaddr);
    assign active = dmemren || dmemwen;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = frames[req.idx][w].valid && (frames[req.idx][w].tag == req.tag);
        end
    end

    assign hit_way  = way_match[1];
    assign dhit     = active && (|way_match);
    assign miss     = active && !(|way_match);
    assign dmemload = frames[req.idx][hit_way].data[req.blkoff];

    // LRU bit names the way to replace next.
    assign fill.victim_way   = lru[req.idx];
    assign fill.victim_frame = frames[req.idx][lru[req.idx]];
    assign scan.scan_frame   = frames[scan.scan_set][scan.scan_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            frames <= '0;
            lru    <= '0;
        end else begin
            if (dhit) begin
                lru[req.idx] <= ~hit_way;
                if (dmemwen) begin
                    frames[req.idx][hit_way].data[req.blkoff] <= dmemstore;
                    frames[req.idx][hit_way].dirty            <= 1'b1;
                end
            end
            // Word 0 of a fill leaves the frame invalid until word 1 lands.
            if (fill.fill_we) begin
                frames[req.idx][fill.fill_way].data[fill.fill_word] <= fill.fill_data;
                frames[req.idx][fill.fill_way].tag                  <= fill.fill_tag;
                frames[req.idx][fill.fill_way].valid                <= fill.mark_valid;
                if (fill.mark_dirty) begin
                    frames[req.idx][fill.fill_way].dirty <= 1'b1;
                end
            end
            // A written-back victim turns clean before its refill.
            if (fill.mark_clean) begin
                frames[req.idx][fill.fill_way].dirty <= 1'b0;
            end
            if (scan.clear_dirty) begin
                frames[scan.scan_set][scan.scan_way].dirty <= 1'b0;
            end
        end
    end

    // Miss fills and the halt flush must never overlap.
    a_fill_vs_flush: assert property (
        @(posedge CLK) disable iff (!nRST) !(fill.fill_we && scan.clear_dirty)
    );

endmodule

`default_nettype wire

/* design/flush_engine.sv */
// Flush engine: walks every word slot at halt and writes dirty words back.
`timescale 1ns/1ps
`default_nettype none

module flush_engine
    import dcache_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic halt,
    input  logic busy,
    output logic flushed,
    scan_if.driver       scan,
    mem_req_if.requester mem
);

    flush_state_t state;
    logic [SLOT_W-1:0] slot;
    logic need_write;
    logic advance;

    // Slot layout is {way, set, word}.
    assign scan.scan_way = slot[SLOT_W-1];
    assign scan.scan_set = slot[IDX_W:1];

    assign need_write = (state == FLUSH_SCAN) && scan.scan_frame.valid && scan.scan_frame.dirty;
    assign advance    = (state == FLUSH_SCAN) && (!need_write || !mem.mwait);

    assign mem.ren   = 1'b0;
    assign mem.wen   = need_write;
    assign mem.addr  = {scan.scan_frame.tag, scan.scan_set, slot[0], 2'b00};
    assign mem.store = scan.scan_frame.data[slot[0]];

    assign scan.clear_dirty = need_write && !mem.mwait && slot[0];
    assign flushed          = (state == FLUSH_DONE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= FLUSH_IDLE;
            slot  <= '0;
        end else begin
            case (state)
                FLUSH_IDLE: if (halt && !busy) state <= FLUSH_SCAN;
                FLUSH_SCAN: begin
                    if (advance) begin
                        slot <= slot + 1'b1;
                        if (&slot) begin
                            state <= FLUSH_DONE;
                        end
                    end
                end
                default: state <= state;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
// Arbiter that shares the memory bus between the miss and flush engines.
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import dcache_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    mem_req_if.server    miss_port,
    mem_req_if.server    flush_port,
    mem_req_if.requester bus
);

    logic miss_req;
    logic flush_req;
    logic grant_miss;
    logic grant_flush;
    logic locked;
    logic lock_flush;

    assign miss_req  = miss_port.ren || miss_port.wen;
    assign flush_req = flush_port.ren || flush_port.wen;

    // Miss engine first, unless a word is already in flight.
    assign grant_miss  = locked ? !lock_flush : miss_req;
    assign grant_flush = locked ? lock_flush : (!miss_req && flush_req);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            locked     <= 1'b0;
            lock_flush <= 1'b0;
        end else if (!locked) begin
            if ((grant_miss || grant_flush) && bus.mwait) begin
                locked     <= 1'b1;
                lock_flush <= grant_flush;
            end
        end else if (!bus.mwait) begin
            locked <= 1'b0;
        end
    end

    always_comb begin
        bus.ren   = 1'b0;
        bus.wen   = 1'b0;
        bus.addr  = miss_port.addr;
        bus.store = miss_port.store;
        if (grant_miss) begin
            bus.ren = miss_port.ren;
            bus.wen = miss_port.wen;
        end else if (grant_flush) begin
            bus.ren   = flush_port.ren;
            bus.wen   = flush_port.wen;
            bus.addr  = flush_port.addr;
            bus.store = flush_port.store;
        end
    end

    assign miss_port.load   = bus.load;
    assign flush_port.load  = bus.load;
    assign miss_port.mwait  = grant_miss ? bus.mwait : 1'b1;
    assign flush_port.mwait = grant_flush ? bus.mwait : 1'b1;

    // A locked grant belongs to a requester that still holds its request.
    a_lock_holds_request: assert property (
        @(posedge CLK) disable iff (!nRST)
        locked |-> (lock_flush ? flush_req : miss_req)
    );

endmodule

`default_nettype wire

/* design/miss_engine.sv */
// Miss engine: dirty victim write-back followed by a two-word block fill.
`timescale 1ns/1ps
`default_nettype none

module miss_engine
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  miss,
    input  logic  dmemwen,
    input  word_t dmemaddr,
    fill_if.driver       fill,
    mem_req_if.requester mem
);

    miss_state_t state;
    miss_state_t next_state;

    dcache_addr_t req;
    logic victim_dirty;
    logic done;
    logic word_sel;

    assign req          = dcache_addr_t'(dmemaddr);
    assign victim_dirty = fill.victim_frame.valid && fill.victim_frame.dirty;
    assign done         = !mem.mwait;
    assign word_sel     = (state == WB_WORD1) || (state == FILL_WORD1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= MISS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MISS_IDLE: begin
                if (miss) begin
                    next_state = victim_dirty ? WB_WORD0 : FILL_WORD0;
                end
            end
            WB_WORD0:   if (done) next_state = WB_WORD1;
            WB_WORD1:   if (done) next_state = FILL_WORD0;
            FILL_WORD0: if (done) next_state = FILL_WORD1;
            FILL_WORD1: if (done) next_state = MISS_IDLE;
            default:    next_state = MISS_IDLE;
        endcase
    end

    assign mem.wen   = (state == WB_WORD0) || (state == WB_WORD1);
    assign mem.ren   = (state == FILL_WORD0) || (state == FILL_WORD1);
    assign mem.store = fill.victim_frame.data[word_sel];

    // Victim address is rebuilt from its stored tag and the request index.
    always_comb begin
        if (mem.wen) begin
            mem.addr = {fill.victim_frame.tag, req.idx, word_sel, 2'b00};
        end else begin
            mem.addr = {req.tag, req.idx, word_sel, 2'b00};
        end
    end

    assign fill.fill_we    = mem.ren && done;
    assign fill.fill_way   = fill.victim_way;
    assign fill.fill_word  = word_sel;
    assign fill.fill_data  = mem.load;
    assign fill.fill_tag   = req.tag;
    assign fill.mark_valid = (state == FILL_WORD1);
    assign fill.mark_dirty = (state == FILL_WORD1) && dmemwen;
    assign fill.mark_clean = (state == WB_WORD1) && done;

    // The request stays a miss until the fill has completed.
    a_miss_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        (state != MISS_IDLE) |-> miss
    );

endmodule

`default_nettype wire

/* dv/dcache_stim.txt */
# R addr expected_load | W addr data | H (halt, wait for flushed)
# M addr expected_memory_word expected_write_count
R 00000010 A5A50010
R 00000014 A5A50014
W 00000100 DEAD0001
R 00000100 DEAD0001
M 00000100 A5A50100 0
R 00000140 A5A50140
R 00000180 A5A50180
R 00000144 A5A50144
R 00000100 DEAD0001
W 00000184 BEEF0002
W 0000001C CAFE0003
R 00000180 A5A50180
M 00000140 A5A50140 0
H
M 00000100 DEAD0001 1
M 00000104 A5A50104 1
M 00000180 A5A50180 1
M 00000184 BEEF0002 1
M 00000018 A5A50018 1
M 0000001C CAFE0003 1
M 00000010 A5A50010 0
M 00000144 A5A50144 0

/* dv/tb_dcache.sv */
// Testbench for the data cache: clock, reset, stimulus file, memory model and checks.
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();
    localparam int MEM_WORDS = 256;

    logic  CLK;
    logic  nRST;
    logic  dmemren;
    logic  dmemwen;
    word_t dmemaddr;
    word_t dmemstore;
    logic  halt;
    word_t dmemload;
    logic  dhit;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_store;
    word_t mem_load;
    logic  mem_wait;

    word_t      mem_words [MEM_WORDS];
    int         write_count [MEM_WORDS];
    logic [1:0] wait_left;
    word_t      lfsr;

    byte   op_q [$];
    word_t addr_q [$];
    word_t data_q [$];
    int    cnt_q [$];

    int errors;
    int checks;
    int cycles;
    int cycle_limit;

    dcache_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .flushed   (flushed),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_store (mem_store),
        .mem_load  (mem_load),
        .mem_wait  (mem_wait)
    );

    always #20 CLK = ~CLK;

    // Taps 32, 22, 2, 1.
    function automatic word_t lfsr_next(input word_t s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        lfsr = lfsr_next(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d[1] = lfsr[0];
    endtask

    // Memory answers combinationally; wait_left counts the extra cycles of the current word.
    assign mem_wait = (mem_ren || mem_wen) && (wait_left != 2'd0);
    assign mem_load = mem_words[mem_addr[9:2]];

    always begin
        logic  req;
        logic  wr;
        logic  stall;
        word_t a;
        word_t d;
        @(negedge CLK);
        req   = mem_ren || mem_wen;
        wr    = mem_wen;
        stall = mem_wait;
        a     = mem_addr;
        d     = mem_store;
        @(posedge CLK);
        #2;
        if (req && !stall) begin
            if (wr) begin
                mem_words[a[9:2]]   = d;
                write_count[a[9:2]] = write_count[a[9:2]] + 1;
            end
            draw_delay(wait_left);
        end else if (req) begin
            wait_left = wait_left - 2'd1;
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Holds the request until dhit, then checks the load for reads.
    task automatic run_access(input logic wr, input word_t a, input word_t d);
        dmemren   = !wr;
        dmemwen   = wr;
        dmemaddr  = a;
        dmemstore = wr ? d : '0;
        @(negedge CLK);
        while (!dhit) begin
            @(negedge CLK);
        end
        if (!wr) begin
            checks = checks + 1;
            if (dmemload !== d) begin
                errors = errors + 1;
                $display("mismatch at %0t: dmemload expected %h got %h", $time, d, dmemload);
            end
        end
        @(posedge CLK);
        #2;
        dmemren = 1'b0;
        dmemwen = 1'b0;
    endtask

    task automatic run_halt();
        halt = 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #2;
    endtask

    task automatic check_memory(input word_t a, input word_t d, input int c);
        @(negedge CLK);
        checks = checks + 2;
        if (mem_words[a[9:2]] !== d) begin
            errors = errors + 1;
            $display("mismatch at %0t: mem_word[%h] expected %h got %h",
                     $time, a, d, mem_words[a[9:2]]);
        end
        if (write_count[a[9:2]] != c) begin
            errors = errors + 1;
            $display("mismatch at %0t: write_count[%h] expected %0d got %0d",
                     $time, a, c, write_count[a[9:2]]);
        end
        @(posedge CLK);
        #2;
    endtask

    initial begin
        int    fd;
        int    ch;
        int    n;
        int    want;
        int    c;
        word_t a;
        word_t d;
        CLK         = 1'b0;
        nRST        = 1'b0;
        dmemren     = 1'b0;
        dmemwen     = 1'b0;
        dmemaddr    = '0;
        dmemstore   = '0;
        halt        = 1'b0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        lfsr        = 32'h3501_5538;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i]   = word_t'(i * 4) ^ 32'hA5A5_0000;
            write_count[i] = 0;
        end
        draw_delay(wait_left);

        fd = $fopen("dv/dcache_stim.txt", "r");
        if (fd == 0) begin
            errors = errors + 1;
            $display("Could not open the stimulus file dv/dcache_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                ch = $fgetc(fd);
                if (ch == "#") begin
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (ch == "R" || ch == "W" || ch == "H" || ch == "M") begin
                    a    = '0;
                    d    = '0;
                    c    = 0;
                    n    = 0;
                    want = 0;
                    if (ch == "R" || ch == "W") begin
                        want = 2;
                        n    = $fscanf(fd, "%h %h", a, d);
                    end else if (ch == "M") begin
                        want = 3;
                        n    = $fscanf(fd, "%h %h %d", a, d, c);
                    end
                    if (n != want) begin
                        errors = errors + 1;
                        $display("Stimulus line for operation %c has missing fields", ch);
                    end
                    op_q.push_back(byte'(ch));
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    cnt_q.push_back(c);
                end
            end
            $fclose(fd);
        end
        cycle_limit = op_q.size() * 40 + 200;

        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;
        @(negedge CLK);
        checks = checks + 1;
        if (dhit !== 1'b0 || flushed !== 1'b0 || mem_ren !== 1'b0 || mem_wen !== 1'b0) begin
            errors = errors + 1;
            $display("Outputs were not idle after reset at %0t", $time);
        end
        @(posedge CLK);
        #2;

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "R":     run_access(1'b0, addr_q[i], data_q[i]);
                "W":     run_access(1'b1, addr_q[i], data_q[i]);
                "H":     run_halt();
                default: check_memory(addr_q[i], data_q[i], cnt_q[i]);
            endcase
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/dcache_pkg.sv
design/dcache_ifs.sv
design/dcache_ways.sv
design/miss_engine.sv
design/flush_engine.sv
design/mem_arbiter.sv
design/dcache_top.sv
dv/tb_dcache.sv
